/* design/jtag_pkg.sv */
package jtag_pkg;

	////////////////////
	// Widths and constants
	////////////////////

	// Instruction register width
	localparam int IR_LENGTH = 4;

	// Loaded into the IR shift stage in Capture-IR
	// Low bits 01 as 1149.1 asks, upper bits fixed for fault detection
	localparam logic [IR_LENGTH-1:0] IR_CAPTURE_PATTERN = 4'b0101;

	// IDCODE data register width
	localparam int IDCODE_LENGTH = 32;

	////////////////////
	// TAP states
	////////////////////

	// Binary encoding, 4 flops for 16 states
	// Test-Logic-Reset sits at all ones
	typedef enum logic [3:0] {
		TAP_EXIT2_DR         = 4'h0,
		TAP_EXIT1_DR         = 4'h1,
		TAP_SHIFT_DR         = 4'h2,
		TAP_PAUSE_DR         = 4'h3,
		TAP_SELECT_IR_SCAN   = 4'h4,
		TAP_UPDATE_DR        = 4'h5,
		TAP_CAPTURE_DR       = 4'h6,
		TAP_SELECT_DR_SCAN   = 4'h7,
		TAP_EXIT2_IR         = 4'h8,
		TAP_EXIT1_IR         = 4'h9,
		TAP_SHIFT_IR         = 4'hA,
		TAP_PAUSE_IR         = 4'hB,
		TAP_RUN_TEST_IDLE    = 4'hC,
		TAP_UPDATE_IR        = 4'hD,
		TAP_CAPTURE_IR       = 4'hE,
		TAP_TEST_LOGIC_RESET = 4'hF
	} tap_state_e;

	////////////////////
	// Instructions
	////////////////////

	// Opcodes held in the active instruction register
	// Codes not listed here decode as bypass
	typedef enum logic [IR_LENGTH-1:0] {
		INSTR_EXTEST         = 4'b0000,
		INSTR_SAMPLE_PRELOAD = 4'b0001,
		INSTR_IDCODE         = 4'b0010,
		INSTR_DEBUG          = 4'b1000,
		INSTR_MBIST          = 4'b1001,
		INSTR_BYPASS         = 4'b1111
	} tap_instr_e;

	// Decoded TAP state, one bit per state of interest
	typedef struct packed {
		logic in_reset;
		logic run_test_idle;
		logic capture_dr;
		logic shift_dr;
		logic pause_dr;
		logic update_dr;
		logic capture_ir;
		logic shift_ir;
		logic pause_ir;
		logic update_ir;
	} tap_flags_t;

	// One-hot data register select from the active instruction
	typedef struct packed {
		logic extest;
		logic sample_preload;
		logic idcode;
		logic mbist;
		logic debug;
		logic bypass;
	} instr_select_t;

endpackage

/* design/tap_fsm.sv */
module tap_fsm (
	input  logic                dif,
	input  logic                test_logic_reset,
	input  logic                tms_i,
	output jtag_pkg::tap_flags_t flags_o
);

	import jtag_pkg::*;

	// Current and next TAP state
	tap_state_e state_q;
	tap_state_e state_d;

	////////////////////
	// State register
	////////////////////

	// Advances on every rising edge of the test clock
	always_ff @(posedge dif)
	begin
		if (test_logic_reset)
		begin
			state_q <= TAP_TEST_LOGIC_RESET;
		end
		else
		begin
			state_q <= state_d;
		end
	end

	////////////////////
	// Next-state table
	////////////////////

	// Standard 1149.1 transitions, TMS picks one of two successors
	always_comb
	begin
		case (state_q)
			TAP_TEST_LOGIC_RESET:
				state_d = tms_i ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
			TAP_RUN_TEST_IDLE:
				state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
			// Data register column
			TAP_SELECT_DR_SCAN:
				state_d = tms_i ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
			TAP_CAPTURE_DR:
				state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR:
				state_d = tms_i ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR:
				state_d = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR:
				state_d = tms_i ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			// Exit2 can resume shifting without a new capture
			TAP_EXIT2_DR:
				state_d = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
			TAP_UPDATE_DR:
				state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
			// Instruction register column
			// TMS high here falls back to reset
			TAP_SELECT_IR_SCAN:
				state_d = tms_i ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
			TAP_CAPTURE_IR:
				state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR:
				state_d = tms_i ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR:
				state_d = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR:
				state_d = tms_i ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR:
				state_d = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
			TAP_UPDATE_IR:
				state_d = tms_i ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
			// Only reachable from a corrupted state register
			default:
				state_d = TAP_TEST_LOGIC_RESET;
		endcase
	end

	////////////////////
	// State flags
	////////////////////

	// Combinational from the state register, valid in the same cycle
	always_comb
	begin
		flags_o.in_reset      = (state_q == TAP_TEST_LOGIC_RESET);
		flags_o.run_test_idle = (state_q == TAP_RUN_TEST_IDLE);
		// DR path
		flags_o.capture_dr    = (state_q == TAP_CAPTURE_DR);
		flags_o.shift_dr      = (state_q == TAP_SHIFT_DR);
		flags_o.pause_dr      = (state_q == TAP_PAUSE_DR);
		flags_o.update_dr     = (state_q == TAP_UPDATE_DR);
		// IR path
		flags_o.capture_ir    = (state_q == TAP_CAPTURE_IR);
		flags_o.shift_ir      = (state_q == TAP_SHIFT_IR);
		flags_o.pause_ir      = (state_q == TAP_PAUSE_IR);
		flags_o.update_ir     = (state_q == TAP_UPDATE_IR);
	end

endmodule

/* design/tap_instruction_reg.sv */
module tap_instruction_reg (
	input  logic                   dif,
	input  logic                   tdi_i,
	input  jtag_pkg::tap_flags_t    flags_i,
	output jtag_pkg::tap_instr_e    instr_o,
	output jtag_pkg::instr_select_t select_o,
	output logic                   ir_tdo_o
);

	import jtag_pkg::*;

	// Capture and shift stage
	logic [IR_LENGTH-1:0] ir_shift_q;
	// Active instruction, drives the decoder
	tap_instr_e           instr_q;

	////////////////////
	// Shift stage
	////////////////////

	// Fixed pattern in Capture-IR, then shift right with TDI into the MSB
	always_ff @(posedge dif)
	begin
		if (flags_i.in_reset)
		begin
			ir_shift_q <= '0;
		end
		else if (flags_i.capture_ir)
		begin
			ir_shift_q <= IR_CAPTURE_PATTERN;
		end
		else if (flags_i.shift_ir)
		begin
			ir_shift_q <= {tdi_i, ir_shift_q[IR_LENGTH-1:1]};
		end
	end

	// LSB leaves first
	assign ir_tdo_o = ir_shift_q[0];

	////////////////////
	// Active instruction
	////////////////////

	// IDCODE comes up after reset
	// Any 4-bit code can be loaded, unknown ones decode below
	always_ff @(posedge dif)
	begin
		if (flags_i.in_reset)
		begin
			instr_q <= INSTR_IDCODE;
		end
		else if (flags_i.update_ir)
		begin
			instr_q <= tap_instr_e'(ir_shift_q);
		end
	end

	assign instr_o = instr_q;

	// One-hot select, unknown opcodes fall to bypass
	always_comb
	begin
		select_o = '0;
		case (instr_q)
			INSTR_EXTEST:         select_o.extest         = 1'b1;
			INSTR_SAMPLE_PRELOAD: select_o.sample_preload = 1'b1;
			INSTR_IDCODE:         select_o.idcode         = 1'b1;
			INSTR_MBIST:          select_o.mbist          = 1'b1;
			INSTR_DEBUG:          select_o.debug          = 1'b1;
			default:              select_o.bypass         = 1'b1;
		endcase
	end

endmodule

/* design/tap_data_regs.sv */
module tap_data_regs #(
	parameter logic [jtag_pkg::IDCODE_LENGTH-1:0] IDCODE_VALUE = 32'h149511C3
) (
	input  logic                   dif,
	input  logic                   tdi_i,
	input  jtag_pkg::tap_flags_t    flags_i,
	input  jtag_pkg::instr_select_t select_i,
	output logic                   idcode_tdo_o,
	output logic                   bypass_tdo_o
);

	import jtag_pkg::*;

	// IDCODE shift register
	logic [IDCODE_LENGTH-1:0] idcode_q;
	// Single-bit bypass stage
	logic                     bypass_q;

	////////////////////
	// IDCODE register
	////////////////////

	// Reloads the device ID in reset and on capture
	// Shifts right only while IDCODE is the active instruction
	always_ff @(posedge dif)
	begin
		if (flags_i.in_reset || (select_i.idcode && flags_i.capture_dr))
		begin
			idcode_q <= IDCODE_VALUE;
		end
		else if (select_i.idcode && flags_i.shift_dr)
		begin
			idcode_q <= {tdi_i, idcode_q[IDCODE_LENGTH-1:1]};
		end
	end

	// LSB leaves first, bit 0 of a valid ID is always 1
	assign idcode_tdo_o = idcode_q[0];

	////////////////////
	// Bypass register
	////////////////////

	// Captures 0, so the first shifted bit out is always 0
	always_ff @(posedge dif)
	begin
		if (flags_i.in_reset || (select_i.bypass && flags_i.capture_dr))
		begin
			bypass_q <= 1'b0;
		end
		else if (select_i.bypass && flags_i.shift_dr)
		begin
			bypass_q <= tdi_i;
		end
	end

	// One cycle of delay from TDI to TDO
	assign bypass_tdo_o = bypass_q;

endmodule

/* design/tap_tdo_mux.sv */
module tap_tdo_mux (
	input  logic                dif,
	input  jtag_pkg::tap_flags_t flags_i,
	input  jtag_pkg::tap_instr_e instr_i,
	input  logic                ir_tdo_i,
	input  logic                idcode_tdo_i,
	input  logic                bypass_tdo_i,
	input  logic                bs_chain_tdo_i,
	input  logic                mbist_tdo_i,
	input  logic                debug_tdo_i,
	output logic                tdo_o,
	output logic                tdo_oe_o
);

	import jtag_pkg::*;

	// Selected serial bit ahead of the output flop
	logic tdo_sel;

	////////////////////
	// Source select
	////////////////////

	// IR wins during Shift-IR, otherwise the active instruction picks the DR
	always_comb
	begin
		if (flags_i.shift_ir)
		begin
			tdo_sel = ir_tdo_i;
		end
		else
		begin
			case (instr_i)
				INSTR_IDCODE:         tdo_sel = idcode_tdo_i;
				INSTR_BYPASS:         tdo_sel = bypass_tdo_i;
				// Both boundary scan opcodes share one chain
				INSTR_EXTEST,
				INSTR_SAMPLE_PRELOAD: tdo_sel = bs_chain_tdo_i;
				INSTR_MBIST:          tdo_sel = mbist_tdo_i;
				INSTR_DEBUG:          tdo_sel = debug_tdo_i;
				// Unlisted codes drive a constant 1
				default:              tdo_sel = 1'b1;
			endcase
		end
	end

	////////////////////
	// Output flops
	////////////////////

	// TDO launches on the falling edge, half a cycle before the far end samples
	always_ff @(negedge dif)
	begin
		tdo_o <= tdo_sel;
	end

	// Enable follows the shift states one edge late
	always_ff @(posedge dif)
	begin
		tdo_oe_o <= flags_i.shift_ir | flags_i.shift_dr;
	end

endmodule

/* design/jtag_tap_top.sv */
module jtag_tap_top #(
	parameter logic [jtag_pkg::IDCODE_LENGTH-1:0] IDCODE_VALUE = 32'h149511C3
) (
	input  logic                   dif,
	input  logic                   test_logic_reset,
	input  logic                   tms_i,
	input  logic                   tdi_i,
	// Serial returns from the external chains
	input  logic                   bs_chain_tdo_i,
	input  logic                   mbist_tdo_i,
	input  logic                   debug_tdo_i,
	// Pad side
	output logic                   tdo_o,
	output logic                   tdo_oe_o,
	// TDI forwarded to the external chains
	output logic                   chain_tdi_o,
	// State and select for the chains and for observation
	output jtag_pkg::tap_flags_t    tap_flags_o,
	output jtag_pkg::instr_select_t select_o
);

	import jtag_pkg::*;

	////////////////////
	// Internal nets
	////////////////////

	tap_flags_t    tap_flags;
	instr_select_t instr_select;
	tap_instr_e    active_instr;
	// Serial bits into the TDO mux
	logic          ir_tdo;
	logic          idcode_tdo;
	logic          bypass_tdo;

	assign tap_flags_o = tap_flags;
	assign select_o    = instr_select;
	// External chains shift from the same TDI
	assign chain_tdi_o = tdi_i;

	// State machine steered by TMS
	tap_fsm u_tap_fsm (
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tms_i            (tms_i),
		.flags_o          (tap_flags)
	);

	// Instruction register and decoder
	tap_instruction_reg u_tap_instruction_reg (
		.dif      (dif),
		.tdi_i    (tdi_i),
		.flags_i  (tap_flags),
		.instr_o  (active_instr),
		.select_o (instr_select),
		.ir_tdo_o (ir_tdo)
	);

	// Internal data registers
	tap_data_regs #(
		.IDCODE_VALUE (IDCODE_VALUE)
	) u_tap_data_regs (
		.dif          (dif),
		.tdi_i        (tdi_i),
		.flags_i      (tap_flags),
		.select_i     (instr_select),
		.idcode_tdo_o (idcode_tdo),
		.bypass_tdo_o (bypass_tdo)
	);

	// Output path
	tap_tdo_mux u_tap_tdo_mux (
		.dif            (dif),
		.flags_i        (tap_flags),
		.instr_i        (active_instr),
		.ir_tdo_i       (ir_tdo),
		.idcode_tdo_i   (idcode_tdo),
		.bypass_tdo_i   (bypass_tdo),
		.bs_chain_tdo_i (bs_chain_tdo_i),
		.mbist_tdo_i    (mbist_tdo_i),
		.debug_tdo_i    (debug_tdo_i),
		.tdo_o          (tdo_o),
		.tdo_oe_o       (tdo_oe_o)
	);

endmodule

/* testbench/tb_jtag_tap.sv */
module tb_jtag_tap;

	timeunit 1ns;
	timeprecision 1ps;

	import jtag_pkg::*;

	localparam logic [31:0] IDCODE_VALUE = 32'h149511C3;

	logic          dif;
	logic          test_logic_reset;
	logic          tms_i;
	logic          tdi_i;
	logic          bs_chain_tdo_i;
	logic          mbist_tdo_i;
	logic          debug_tdo_i;
	logic          tdo_o;
	logic          tdo_oe_o;
	logic          chain_tdi_o;
	tap_flags_t    tap_flags_o;
	instr_select_t select_o;

	// Reference model registers follow the DUT on every rising edge
	tap_state_e  m_state;
	logic [3:0]  m_ir_shift;
	logic [3:0]  m_instr;
	logic [31:0] m_idcode;
	logic        m_bypass;
	logic        m_oe;

	// LCG state, last samples and per-shift logs of the chain inputs
	logic [31:0] seed = 32'd66864;
	int          errors = 0;
	logic        s_tdo;
	logic        s_oe;
	logic [31:0] log_bs;
	logic [31:0] log_mbist;
	logic [31:0] log_debug;
	tap_instr_e  chain_ops [4] = '{INSTR_EXTEST, INSTR_SAMPLE_PRELOAD, INSTR_MBIST, INSTR_DEBUG};

	jtag_tap_top u_jtag_tap_top (
		.dif              (dif),
		.test_logic_reset (test_logic_reset),
		.tms_i            (tms_i),
		.tdi_i            (tdi_i),
		.bs_chain_tdo_i   (bs_chain_tdo_i),
		.mbist_tdo_i      (mbist_tdo_i),
		.debug_tdo_i      (debug_tdo_i),
		.tdo_o            (tdo_o),
		.tdo_oe_o         (tdo_oe_o),
		.chain_tdi_o      (chain_tdi_o),
		.tap_flags_o      (tap_flags_o),
		.select_o         (select_o)
	);

	// 4 ns test clock
	initial
	begin
		dif = 1'b0;
		forever #2 dif = ~dif;
	end

	////////////////////
	// Model functions
	////////////////////

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// 1149.1 state diagram
	function automatic tap_state_e next_state(input tap_state_e s, input logic tms);
		case (s)
			TAP_TEST_LOGIC_RESET: return tms ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
			TAP_RUN_TEST_IDLE:    return tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
			TAP_SELECT_DR_SCAN:   return tms ? TAP_SELECT_IR_SCAN : TAP_CAPTURE_DR;
			TAP_CAPTURE_DR:       return tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR:         return tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR:         return tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR:         return tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			TAP_EXIT2_DR:         return tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
			TAP_UPDATE_DR:        return tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
			TAP_SELECT_IR_SCAN:   return tms ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
			TAP_CAPTURE_IR:       return tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR:         return tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR:         return tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR:         return tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR:         return tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
			default:              return tms ? TAP_SELECT_DR_SCAN : TAP_RUN_TEST_IDLE;
		endcase
	endfunction

	function automatic tap_flags_t expected_flags(input tap_state_e s);
		tap_flags_t f;
		f.in_reset      = (s == TAP_TEST_LOGIC_RESET);
		f.run_test_idle = (s == TAP_RUN_TEST_IDLE);
		f.capture_dr    = (s == TAP_CAPTURE_DR);
		f.shift_dr      = (s == TAP_SHIFT_DR);
		f.pause_dr      = (s == TAP_PAUSE_DR);
		f.update_dr     = (s == TAP_UPDATE_DR);
		f.capture_ir    = (s == TAP_CAPTURE_IR);
		f.shift_ir      = (s == TAP_SHIFT_IR);
		f.pause_ir      = (s == TAP_PAUSE_IR);
		f.update_ir     = (s == TAP_UPDATE_IR);
		return f;
	endfunction

	// Codes outside the six listed ones select bypass
	function automatic instr_select_t expected_select(input logic [3:0] code);
		instr_select_t sel;
		sel = '0;
		case (code)
			4'b0000: sel.extest         = 1'b1;
			4'b0001: sel.sample_preload = 1'b1;
			4'b0010: sel.idcode         = 1'b1;
			4'b1001: sel.mbist          = 1'b1;
			4'b1000: sel.debug          = 1'b1;
			default: sel.bypass         = 1'b1;
		endcase
		return sel;
	endfunction

	// Bit that the last falling edge should have launched
	function automatic logic expected_tdo();
		if (m_state == TAP_SHIFT_IR)
			return m_ir_shift[0];
		case (m_instr)
			4'b0010:          return m_idcode[0];
			4'b1111:          return m_bypass;
			4'b0000, 4'b0001: return bs_chain_tdo_i;
			4'b1001:          return mbist_tdo_i;
			4'b1000:          return debug_tdo_i;
			default:          return 1'b1;
		endcase
	endfunction

	////////////////////
	// Checks
	////////////////////

	task automatic check_flags(input tap_flags_t act, input tap_flags_t exp);
		if (act !== exp)
		begin
			$display("[ERROR] tap_flags_o: got %h, expected %h", act, exp);
			errors++;
		end
	endtask

	task automatic check_select(input instr_select_t act, input instr_select_t exp);
		if (act !== exp)
		begin
			$display("[ERROR] select_o: got %h, expected %h", act, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp)
		begin
			$display("[ERROR] %s: got %h, expected %h", name, act, exp);
			errors++;
		end
	endtask

	////////////////////
	// Cycle driver
	////////////////////

	// Runs from 1 ns after one rising edge to 1 ns after the next
	task automatic tick(input logic tms, input logic tdi, input logic rst);
		logic [31:0]   rv;
		tap_state_e    s;
		logic [3:0]    old_ir;
		instr_select_t sel;
		rv = next_random();
		tms_i = tms;
		tdi_i = tdi;
		test_logic_reset = rst;
		bs_chain_tdo_i = rv[8];
		mbist_tdo_i = rv[12];
		debug_tdo_i = rv[18];
		// Sample just before the next rising edge
		#2.5;
		s_tdo = tdo_o;
		s_oe = tdo_oe_o;
		check_flags(tap_flags_o, expected_flags(m_state));
		check_select(select_o, expected_select(m_instr));
		check_bit("tdo_o", tdo_o, expected_tdo());
		check_bit("tdo_oe_o", tdo_oe_o, m_oe);
		check_bit("chain_tdi_o", chain_tdi_o, tdi);
		@(posedge dif);
		// Registers move with the state held before this edge
		s = m_state;
		old_ir = m_ir_shift;
		sel = expected_select(m_instr);
		m_oe = (s == TAP_SHIFT_IR) || (s == TAP_SHIFT_DR);
		if (s == TAP_TEST_LOGIC_RESET)
			m_ir_shift = '0;
		else if (s == TAP_CAPTURE_IR)
			m_ir_shift = IR_CAPTURE_PATTERN;
		else if (s == TAP_SHIFT_IR)
			m_ir_shift = {tdi, m_ir_shift[3:1]};
		if (s == TAP_TEST_LOGIC_RESET)
			m_instr = INSTR_IDCODE;
		else if (s == TAP_UPDATE_IR)
			m_instr = old_ir;
		if (s == TAP_TEST_LOGIC_RESET || (sel.idcode && s == TAP_CAPTURE_DR))
			m_idcode = IDCODE_VALUE;
		else if (sel.idcode && s == TAP_SHIFT_DR)
			m_idcode = {tdi, m_idcode[31:1]};
		if (s == TAP_TEST_LOGIC_RESET || (sel.bypass && s == TAP_CAPTURE_DR))
			m_bypass = 1'b0;
		else if (sel.bypass && s == TAP_SHIFT_DR)
			m_bypass = tdi;
		m_state = rst ? TAP_TEST_LOGIC_RESET : next_state(s, tms);
		#1;
	endtask

	// Hold TMS until the DUT flags show the target state
	task automatic wait_state(input tap_state_e target, input logic tms, input int limit);
		int n;
		for (n = 0; n < limit && tap_flags_o !== expected_flags(target); n++)
			tick(tms, 1'b0, 1'b0);
		if (tap_flags_o !== expected_flags(target))
		begin
			$display("Timeout: TAP did not reach %s within %0d cycles", target.name(), limit);
			errors++;
		end
	endtask

	// Reset from anywhere by TMS high and park in Run-Test/Idle
	task automatic go_idle();
		wait_state(TAP_TEST_LOGIC_RESET, 1'b1, 5);
		wait_state(TAP_RUN_TEST_IDLE, 1'b0, 2);
	endtask

	// Load an opcode from Run-Test/Idle and check the captured pattern on the way
	task automatic load_ir(input logic [3:0] op);
		int i;
		tick(1'b1, 1'b0, 1'b0);
		tick(1'b1, 1'b0, 1'b0);
		wait_state(TAP_SHIFT_IR, 1'b0, 3);
		for (i = 0; i < 4; i++)
		begin
			tick(i == 3, op[i], 1'b0);
			check_bit("tdo_o", s_tdo, IR_CAPTURE_PATTERN[i]);
		end
		tick(1'b1, 1'b0, 1'b0);
		wait_state(TAP_RUN_TEST_IDLE, 1'b0, 2);
		check_select(select_o, expected_select(op));
	endtask

	// Capture and shift n bits of the selected data register LSB first
	task automatic scan_dr(input int n, input logic [31:0] tdi_bits, output logic [31:0] tdo_bits);
		int i;
		tdo_bits = '0;
		tick(1'b1, 1'b0, 1'b0);
		wait_state(TAP_SHIFT_DR, 1'b0, 3);
		for (i = 0; i < n; i++)
		begin
			tick(i == n - 1, tdi_bits[i], 1'b0);
			tdo_bits[i] = s_tdo;
			log_bs[i] = bs_chain_tdo_i;
			log_mbist[i] = mbist_tdo_i;
			log_debug[i] = debug_tdo_i;
			if (i > 0)
				check_bit("tdo_oe_o", s_oe, 1'b1);
		end
		tick(1'b1, 1'b0, 1'b0);
		wait_state(TAP_RUN_TEST_IDLE, 1'b0, 2);
	endtask

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		int          i;
		int          k;
		int          ones_run;
		logic [31:0] rv;
		logic [31:0] tdi_bits;
		logic [31:0] tdo_bits;
		logic [31:0] exp_bits;
		test_logic_reset = 1'b1;
		tms_i = 1'b1;
		tdi_i = 1'b0;
		bs_chain_tdo_i = 1'b0;
		mbist_tdo_i = 1'b0;
		debug_tdo_i = 1'b0;
		repeat (2) @(posedge dif);
		#1;
		test_logic_reset = 1'b0;
		m_state = TAP_TEST_LOGIC_RESET;
		m_ir_shift = '0;
		m_instr = INSTR_IDCODE;
		m_idcode = IDCODE_VALUE;
		m_bypass = 1'b0;
		m_oe = 1'b0;

		// Random TMS walk with rare reset pulses
		ones_run = 0;
		for (i = 0; i < 2000; i++)
		begin
			rv = next_random();
			ones_run = rv[20] ? ones_run + 1 : 0;
			tick(rv[20], rv[24], rv[15:9] == 7'd0);
			if (ones_run >= 5)
				check_bit("tap_flags_o.in_reset", tap_flags_o.in_reset, 1'b1);
		end

		// IDCODE comes out LSB first after reset
		go_idle();
		scan_dr(32, 32'h0, tdo_bits);
		for (i = 0; i < 32; i++)
			check_bit("tdo_o", tdo_bits[i], IDCODE_VALUE[i]);

		// Random opcodes with listed and unlisted codes
		for (k = 0; k < 16; k++)
		begin
			rv = next_random();
			load_ir(rv[19:16]);
		end
		load_ir(4'b0111);

		// Bypass delays TDI by one shift and starts with a 0
		load_ir(INSTR_BYPASS);
		tdi_bits = next_random();
		scan_dr(32, tdi_bits, tdo_bits);
		check_bit("tdo_o", tdo_bits[0], 1'b0);
		for (i = 1; i < 32; i++)
			check_bit("tdo_o", tdo_bits[i], tdi_bits[i-1]);

		// External chains routed straight to TDO
		for (k = 0; k < 4; k++)
		begin
			load_ir(chain_ops[k]);
			tdi_bits = next_random();
			scan_dr(16, tdi_bits, tdo_bits);
			if (chain_ops[k] == INSTR_MBIST)
				exp_bits = log_mbist;
			else if (chain_ops[k] == INSTR_DEBUG)
				exp_bits = log_debug;
			else
				exp_bits = log_bs;
			for (i = 0; i < 16; i++)
				check_bit("tdo_o", tdo_bits[i], exp_bits[i]);
		end

		$display("Simulation finished with %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* files.f */
design/jtag_pkg.sv
design/tap_fsm.sv
design/tap_instruction_reg.sv
design/tap_data_regs.sv
design/tap_tdo_mux.sv
design/jtag_tap_top.sv
testbench/tb_jtag_tap.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_jtag_tap -f files.f -o tb_jtag_tap
sim_out="$(./obj_dir/tb_jtag_tap)"
echo "$sim_out"

if grep -qx "No errors" <<< "$sim_out"; then
	exit 0
fi
exit 1
